//--- sim.f
+incdir+include
hw/dcachePkg.sv
hw/reqStage.sv
hw/tagStore.sv
hw/lineStore.sv
hw/refillBuffer.sv
hw/missControl.sv
hw/dcacheTop.sv
bench/dcache_props.sv
bench/dcacheTb.sv

//--- run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module dcacheTb -f sim.f -o dcacheSim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/dcacheSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
  exit 0
fi
exit 1

//--- bench/dcacheTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcacheTb;
  import dcachePkg::*;

  localparam int NumOps = 220;
  // worst-case cycles for one miss including memory delays and beat gaps
  localparam int MissBound = 60;

  logic clk, rst_n, reqValid, wrReady, rdReady, rdBeatValid, rdLast;
  memOp_e reqOp;
  addr_t reqAddr, wrReqAddr, rdReqAddr;
  word_t wrData, rdData, rdBeatData;
  byteMask_t wrMask;
  logic addrOk, dataOk, wrReqValid, rdReqValid;
  line_t wrReqData;

  word_t shadow [addr_t];
  word_t mem [addr_t];
  tag_t mTag [2][`DC_SETS];
  bit mValid [2][`DC_SETS];
  bit mDirty [2][`DC_SETS];
  bit mRr [`DC_SETS];

  word_t expData [$];
  bit expLoad [$];
  bit expHit [$];
  time expTime [$];
  addr_t wbAddrQ [$];
  line_t wbLineQ [$];
  addr_t rdAddrQ [$];

  int errors = 0;
  int tests = 0;
  int rdCount = 0;
  int wrCount = 0;
  int seedDummy;

  dcacheTop i_dcacheTop (
    .clk(clk), .rst_n(rst_n),
    .reqValid_i(reqValid), .reqOp_i(reqOp), .reqAddr_i(reqAddr),
    .wrData_i(wrData), .wrMask_i(wrMask),
    .addrOk_o(addrOk), .dataOk_o(dataOk), .rdData_o(rdData),
    .wrReqValid_o(wrReqValid), .wrReqAddr_o(wrReqAddr), .wrReqData_o(wrReqData),
    .wrReady_i(wrReady), .rdReqValid_o(rdReqValid), .rdReqAddr_o(rdReqAddr),
    .rdReady_i(rdReady), .rdBeatValid_i(rdBeatValid), .rdBeatData_i(rdBeatData),
    .rdLast_i(rdLast)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // initial memory contents unique per word address
  function automatic word_t fillPattern(addr_t a);
    return {a, ~a};
  endfunction

  function automatic word_t shadowRead(addr_t a);
    return shadow.exists(a) ? shadow[a] : fillPattern(a);
  endfunction

  // expected load result from the shadow memory
  function automatic word_t expectedLoad(addr_t a);
    return shadowRead({a[31:3], 3'b000});
  endfunction

  function automatic line_t shadowLine(addr_t base);
    line_t l;
    for (int w = 0; w < `DC_BEATS; w++) begin
      l[w*64 +: 64] = shadowRead(base + addr_t'(w * 8));
    end
    return l;
  endfunction

  function automatic void mergeStore(addr_t a, word_t d, byteMask_t m);
    word_t old;
    old = shadowRead({a[31:3], 3'b000});
    for (int b = 0; b < 8; b++) begin
      if (m[b]) old[b*8 +: 8] = d[b*8 +: 8];
    end
    shadow[{a[31:3], 3'b000}] = old;
  endfunction

  // predict hit or miss, victim and writeback from the tag model
  function automatic void noteAccept(memOp_e op, addr_t a, word_t d, byteMask_t m);
    index_t idx;
    tag_t tg;
    bit isHit;
    bit way;
    idx = a[10:5];
    tg = a[31:11];
    isHit = 1'b0;
    way = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (mValid[w][idx] && mTag[w][idx] == tg) begin
        isHit = 1'b1;
        way = w[0];
      end
    end
    if (!isHit) begin
      way = mRr[idx];
      if (mValid[way][idx] && mDirty[way][idx]) begin
        wbAddrQ.push_back({mTag[way][idx], idx, 5'b0});
        wbLineQ.push_back(shadowLine({mTag[way][idx], idx, 5'b0}));
      end
      rdAddrQ.push_back({a[31:5], 5'b0});
      mTag[way][idx] = tg;
      mValid[way][idx] = 1'b1;
      mDirty[way][idx] = 1'b0;
      mRr[idx] = ~mRr[idx];
    end
    if (op == OP_STORE) begin
      mDirty[way][idx] = 1'b1;
      mergeStore(a, d, m);
    end
    expLoad.push_back(op == OP_LOAD);
    expData.push_back(expectedLoad(a));
    expHit.push_back(isHit);
    expTime.push_back($time);
  endfunction

  // called right after a rising edge and returns after the acceptance edge
  task automatic issue(memOp_e op, addr_t a, word_t d, byteMask_t m);
    reqValid <= 1'b1;
    reqOp <= op;
    reqAddr <= a;
    wrData <= d;
    wrMask <= m;
    @(posedge clk);
    while (!addrOk) @(posedge clk);
    noteAccept(op, a, d, m);
  endtask

  task automatic drain();
    reqValid <= 1'b0;
    while (expData.size() > 0) @(posedge clk);
    @(posedge clk);
  endtask

  task automatic compareLevel(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %0s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // a request behind a hit is taken on the very next edge
  task automatic checkBackToBack(time prev);
    if ($time != prev + 20) begin
      $display("Error at %0t: request was not accepted in the cycle after the previous one",
               $time);
      errors++;
    end
  endtask

  task automatic reportTest(string name, int errBefore);
    tests++;
    $display("test %0s: %0s", name, (errors == errBefore) ? "ok" : "FAILED");
  endtask

  // compare every answer with the queue of expected results
  initial begin
    word_t e;
    bit isLoad;
    bit isHit;
    time t;
    forever begin
      @(posedge clk);
      if (dataOk) begin
        if (expData.size() == 0) begin
          $display("Error at %0t: dataOk_o with no request outstanding", $time);
          errors++;
        end else begin
          e = expData.pop_front();
          isLoad = expLoad.pop_front();
          isHit = expHit.pop_front();
          t = expTime.pop_front();
          if (isLoad && rdData !== e) begin
            $display("Mismatch at %0t: rdData_o got %h expected %h", $time, rdData, e);
            errors++;
          end
          if (isHit && $time != t + 20) begin
            $display("Mismatch at %0t: dataOk_o time got %0t expected %0t",
                     $time, $time, t + 20);
            errors++;
          end
        end
      end
    end
  end

  // memory model with random delays
  initial begin
    addr_t ea;
    line_t el;
    word_t w;
    forever begin
      @(posedge clk);
      if (wrReqValid) begin
        wrCount++;
        repeat ($urandom_range(3, 0)) @(posedge clk);
        if (wbAddrQ.size() == 0) begin
          $display("Error at %0t: writeback that the model did not predict", $time);
          errors++;
        end else begin
          ea = wbAddrQ.pop_front();
          el = wbLineQ.pop_front();
          if (wrReqAddr !== ea) begin
            $display("Mismatch at %0t: wrReqAddr_o got %h expected %h", $time, wrReqAddr, ea);
            errors++;
          end
          if (wrReqData !== el) begin
            $display("Mismatch at %0t: wrReqData_o got %h expected %h", $time, wrReqData, el);
            errors++;
          end
        end
        for (int k = 0; k < `DC_BEATS; k++) begin
          mem[wrReqAddr + addr_t'(k * 8)] = wrReqData[k*64 +: 64];
        end
        wrReady <= 1'b1;
        @(posedge clk);
        wrReady <= 1'b0;
      end else if (rdReqValid) begin
        rdCount++;
        if (wbAddrQ.size() != 0) begin
          $display("Error at %0t: refill request came before the expected writeback", $time);
          errors++;
        end
        if (rdAddrQ.size() == 0) begin
          $display("Error at %0t: read request that the model did not predict", $time);
          errors++;
        end else begin
          ea = rdAddrQ.pop_front();
          if (rdReqAddr !== ea) begin
            $display("Mismatch at %0t: rdReqAddr_o got %h expected %h", $time, rdReqAddr, ea);
            errors++;
          end
        end
        ea = rdReqAddr;
        repeat ($urandom_range(3, 0)) @(posedge clk);
        rdReady <= 1'b1;
        @(posedge clk);
        rdReady <= 1'b0;
        for (int k = 0; k < `DC_BEATS; k++) begin
          rdBeatValid <= 1'b0;
          repeat ($urandom_range(2, 0)) @(posedge clk);
          w = mem.exists(ea + addr_t'(k * 8)) ? mem[ea + addr_t'(k * 8)]
                                               : fillPattern(ea + addr_t'(k * 8));
          rdBeatValid <= 1'b1;
          rdBeatData <= w;
          rdLast <= (k == `DC_BEATS - 1);
          @(posedge clk);
        end
        rdBeatValid <= 1'b0;
        rdLast <= 1'b0;
      end
    end
  end

  // watchdog sized from the operation count
  initial begin
    #(NumOps * MissBound * 20);
    $display("Error: run did not finish within the time limit");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int e0;
    int r0;
    int w0;
    time t0;
    addr_t a;
    seedDummy = $urandom(32'h7168);
    rst_n <= 1'b0;
    reqValid <= 1'b0;
    reqOp <= OP_LOAD;
    reqAddr <= '0;
    wrData <= '0;
    wrMask <= '0;
    wrReady <= 1'b0;
    rdReady <= 1'b0;
    rdBeatValid <= 1'b0;
    rdBeatData <= '0;
    rdLast <= 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    e0 = errors;
    compareLevel("addrOk_o", addrOk, 1'b1);
    compareLevel("dataOk_o", dataOk, 1'b0);
    compareLevel("rdReqValid_o", rdReqValid, 1'b0);
    compareLevel("wrReqValid_o", wrReqValid, 1'b0);
    reportTest("reset", e0);

    e0 = errors;
    r0 = rdCount;
    w0 = wrCount;
    issue(OP_LOAD, 32'h0000_1008, '0, '0);
    drain();
    if (rdCount - r0 != 1 || wrCount != w0) begin
      $display("Error: cold miss gave %0d reads and %0d writes", rdCount - r0, wrCount - w0);
      errors++;
    end
    reportTest("cold load miss", e0);

    e0 = errors;
    issue(OP_LOAD, 32'h0000_1000, '0, '0);
    t0 = $time;
    issue(OP_LOAD, 32'h0000_1010, '0, '0);
    checkBackToBack(t0);
    t0 = $time;
    issue(OP_LOAD, 32'h0000_1018, '0, '0);
    checkBackToBack(t0);
    drain();
    reportTest("back-to-back hits", e0);

    e0 = errors;
    issue(OP_STORE, 32'h0000_1010, 64'h1122_3344_5566_7788, 8'h5A);
    t0 = $time;
    issue(OP_LOAD, 32'h0000_1010, '0, '0);
    checkBackToBack(t0);
    drain();
    reportTest("store then load", e0);

    // three tags in set 5 with the first two dirty
    e0 = errors;
    w0 = wrCount;
    issue(OP_STORE, {21'h0A1, 6'd5, 5'h08}, 64'hDEAD_BEEF_0000_0001, 8'hFF);
    issue(OP_STORE, {21'h0A2, 6'd5, 5'h10}, 64'hDEAD_BEEF_0000_0002, 8'h0F);
    issue(OP_LOAD, {21'h0A3, 6'd5, 5'h00}, '0, '0);
    drain();
    if (wrCount - w0 != 1) begin
      $display("Error: expected one writeback on eviction, saw %0d", wrCount - w0);
      errors++;
    end
    reportTest("dirty eviction", e0);

    e0 = errors;
    for (int i = 0; i < 200; i++) begin
      a = {21'($urandom_range(4, 1)), 6'($urandom_range(3, 0)), 2'($urandom), 3'b000};
      if ($urandom_range(1, 0) == 1) begin
        issue(OP_STORE, a, {$urandom, $urandom}, 8'($urandom));
      end else begin
        issue(OP_LOAD, a, '0, '0);
      end
    end
    drain();
    reportTest("random mix", e0);

    $display("tests %0d, errors %0d, reads %0d, writebacks %0d",
             tests, errors, rdCount, wrCount);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/dcache_props.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheProps (
  input logic                   clk,
  input logic                   rst_n,
  input dcachePkg::cacheState_e state_i,
  input logic                   dataOk_i,
  input logic                   wrReqValid_i,
  input logic                   rdReqValid_i,
  input logic                   wrReady_i,
  input logic                   rdReady_i
);
  import dcachePkg::*;

  // memory strobes are levels that hold until ready
  wrHold: assert property (@(posedge clk) disable iff (!rst_n)
    wrReqValid_i && !wrReady_i |=> wrReqValid_i)
    else $error("wrReqValid dropped before wrReady");

  rdHold: assert property (@(posedge clk) disable iff (!rst_n)
    rdReqValid_i && !rdReady_i |=> rdReqValid_i)
    else $error("rdReqValid dropped before rdReady");

  oneReq: assert property (@(posedge clk) disable iff (!rst_n)
    !(wrReqValid_i && rdReqValid_i))
    else $error("read and write requests both high");

  noAnswerInRefill: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == REFILL) |-> !dataOk_i)
    else $error("dataOk during refill");

endmodule

bind missControl dcacheProps i_dcacheProps (
  .clk          (clk),
  .rst_n        (rst_n),
  .state_i      (state),
  .dataOk_i     (dataOk_o),
  .wrReqValid_i (wrReqValid_o),
  .rdReqValid_i (rdReqValid_o),
  .wrReady_i    (wrReady_i),
  .rdReady_i    (rdReady_i)
);

`default_nettype wire

//--- hw/dcacheTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcacheTop (
  input  logic                 clk,
  input  logic                 rst_n,
  // pipeline side
  input  logic                 reqValid_i,
  input  dcachePkg::memOp_e    reqOp_i,
  input  dcachePkg::addr_t     reqAddr_i,
  input  dcachePkg::word_t     wrData_i,
  input  dcachePkg::byteMask_t wrMask_i,
  output logic                 addrOk_o,
  output logic                 dataOk_o,
  output dcachePkg::word_t     rdData_o,
  // memory side
  output logic                 wrReqValid_o,
  output dcachePkg::addr_t     wrReqAddr_o,
  output dcachePkg::line_t     wrReqData_o,
  input  logic                 wrReady_i,
  output logic                 rdReqValid_o,
  output dcachePkg::addr_t     rdReqAddr_o,
  input  logic                 rdReady_i,
  input  logic                 rdBeatValid_i,
  input  dcachePkg::word_t     rdBeatData_i,
  input  logic                 rdLast_i
);
  import dcachePkg::*;

  logic      accept;
  addr_t     heldAddr;
  memOp_e    heldOp;
  word_t     heldData;
  byteMask_t heldMask;
  logic      hit;
  logic      hitWay;
  logic      victimWay;
  logic      victimDirty;
  tag_t      victimTag;
  logic      storeHit;
  logic      fill;
  logic      refillActive;
  line_t     fillLine;

  // line-aligned addresses for the memory side
  assign rdReqAddr_o = {heldAddr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
  assign wrReqAddr_o = {victimTag, heldAddr[`DC_OFFSET_W +: `DC_INDEX_W],
                        {`DC_OFFSET_W{1'b0}}};

  reqStage i_reqStage (
    .clk        (clk),
    .rst_n      (rst_n),
    .reqValid_i (reqValid_i),
    .reqOp_i    (reqOp_i),
    .reqAddr_i  (reqAddr_i),
    .wrData_i   (wrData_i),
    .wrMask_i   (wrMask_i),
    .addrOk_i   (addrOk_o),
    .accept_o   (accept),
    .heldAddr_o (heldAddr),
    .heldOp_o   (heldOp),
    .heldData_o (heldData),
    .heldMask_o (heldMask)
  );

  tagStore i_tagStore (
    .clk           (clk),
    .rst_n         (rst_n),
    .heldAddr_i    (heldAddr),
    .storeHit_i    (storeHit),
    .fill_i        (fill),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimWay_o   (victimWay),
    .victimDirty_o (victimDirty),
    .victimTag_o   (victimTag)
  );

  lineStore i_lineStore (
    .clk          (clk),
    .accept_i     (accept),
    .reqIndex_i   (reqAddr_i[`DC_OFFSET_W +: `DC_INDEX_W]),
    .heldAddr_i   (heldAddr),
    .hitWay_i     (hitWay),
    .victimWay_i  (victimWay),
    .storeHit_i   (storeHit),
    .storeData_i  (heldData),
    .storeMask_i  (heldMask),
    .fill_i       (fill),
    .fillLine_i   (fillLine),
    .rdWord_o     (rdData_o),
    .victimLine_o (wrReqData_o)
  );

  missControl i_missControl (
    .clk            (clk),
    .rst_n          (rst_n),
    .accept_i       (accept),
    .hit_i          (hit),
    .heldOp_i       (heldOp),
    .victimDirty_i  (victimDirty),
    .wrReady_i      (wrReady_i),
    .rdReady_i      (rdReady_i),
    .rdLast_i       (rdLast_i),
    .addrOk_o       (addrOk_o),
    .dataOk_o       (dataOk_o),
    .storeHit_o     (storeHit),
    .fill_o         (fill),
    .refillActive_o (refillActive),
    .wrReqValid_o   (wrReqValid_o),
    .rdReqValid_o   (rdReqValid_o)
  );

  refillBuffer i_refillBuffer (
    .clk            (clk),
    .rst_n          (rst_n),
    .refillActive_i (refillActive),
    .rdBeatValid_i  (rdBeatValid_i),
    .rdBeatData_i   (rdBeatData_i),
    .fillLine_o     (fillLine)
  );

endmodule

`default_nettype wire

//--- hw/missControl.sv
`timescale 1ns/1ps
`default_nettype none

module missControl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              accept_i,
  input  logic              hit_i,
  input  dcachePkg::memOp_e heldOp_i,
  input  logic              victimDirty_i,
  input  logic              wrReady_i,
  input  logic              rdReady_i,
  input  logic              rdLast_i,
  output logic              addrOk_o,
  output logic              dataOk_o,
  output logic              storeHit_o,
  output logic              fill_o,
  output logic              refillActive_o,
  output logic              wrReqValid_o,
  output logic              rdReqValid_o
);
  import dcachePkg::*;

  cacheState_e state;
  cacheState_e stateNext;
  logic        compareHit;

  assign compareHit = (state == COMPARE) && hit_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      IDLE: begin
        if (accept_i) begin
          stateNext = COMPARE;
        end
      end
      COMPARE: begin
        if (hit_i) begin
          // a request taken in this cycle is looked up next cycle
          stateNext = accept_i ? COMPARE : IDLE;
        end else if (victimDirty_i) begin
          stateNext = WRITEBACK;
        end else begin
          stateNext = REFILLREQ;
        end
      end
      WRITEBACK: begin
        if (wrReady_i) begin
          stateNext = REFILLREQ;
        end
      end
      REFILLREQ: begin
        if (rdReady_i) begin
          stateNext = REFILL;
        end
      end
      REFILL: begin
        // last beat lands in the buffer on this edge
        if (rdLast_i) begin
          stateNext = REPLACE;
        end
      end
      REPLACE: begin
        stateNext = COMPARE;
      end
      default: begin
        stateNext = IDLE;
      end
    endcase
  end

  // new address only when idle or when the current lookup hits
  assign addrOk_o = (state == IDLE) || compareHit;
  assign dataOk_o = compareHit;

  // store hits write the line and mark it dirty
  assign storeHit_o = compareHit && (heldOp_i == OP_STORE);
  assign fill_o     = (state == REPLACE);

  assign refillActive_o = (state == REFILL);

  // memory strobes are levels, held until the ready cycle
  assign wrReqValid_o = (state == WRITEBACK);
  assign rdReqValid_o = (state == REFILLREQ);

endmodule

`default_nettype wire

//--- hw/refillBuffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module refillBuffer (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             refillActive_i,
  input  logic             rdBeatValid_i,
  input  dcachePkg::word_t rdBeatData_i,
  output dcachePkg::line_t fillLine_o
);
  import dcachePkg::*;

  logic [$clog2(`DC_BEATS)-1:0] beatCnt;
  line_t                        lineBuf;
  logic                         beatTake;

  assign beatTake = refillActive_i && rdBeatValid_i;

  // wraps to zero after the last beat, ready for the next refill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beatTake) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // lowest word first
  always_ff @(posedge clk) begin
    if (beatTake) begin
      lineBuf[beatCnt*`DC_WORD_W +: `DC_WORD_W] <= rdBeatData_i;
    end
  end

  assign fillLine_o = lineBuf;

endmodule

`default_nettype wire

//--- hw/lineStore.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module lineStore (
  input  logic                 clk,
  input  logic                 accept_i,
  input  dcachePkg::index_t    reqIndex_i,
  input  dcachePkg::addr_t     heldAddr_i,
  input  logic                 hitWay_i,
  input  logic                 victimWay_i,
  input  logic                 storeHit_i,
  input  dcachePkg::word_t     storeData_i,
  input  dcachePkg::byteMask_t storeMask_i,
  input  logic                 fill_i,
  input  dcachePkg::line_t     fillLine_i,
  output dcachePkg::word_t     rdWord_o,
  output dcachePkg::line_t     victimLine_o
);
  import dcachePkg::*;

  localparam int SelW = $clog2(`DC_BEATS);

  line_t dataMem [2][`DC_SETS];
  line_t rdLine  [2];

  index_t          heldIndex;
  index_t          rdIndex;
  logic [SelW-1:0] wordSel;
  word_t           hitWord;
  word_t           mergedWord;
  line_t           mergedLine;
  line_t           wrLine;
  logic [1:0]      wrEn;

  assign heldIndex = heldAddr_i[`DC_OFFSET_W +: `DC_INDEX_W];
  assign wordSel   = heldAddr_i[`DC_OFFSET_W-1 -: SelW];
  // new request's set on acceptance, else keep reading the held set
  assign rdIndex   = accept_i ? reqIndex_i : heldIndex;

  assign hitWord = rdLine[hitWay_i][wordSel*`DC_WORD_W +: `DC_WORD_W];

  // byte merge of store data into the hit word
  always_comb begin
    mergedWord = hitWord;
    for (int b = 0; b < `DC_MASK_W; b++) begin
      if (storeMask_i[b]) begin
        mergedWord[b*8 +: 8] = storeData_i[b*8 +: 8];
      end
    end
    mergedLine = rdLine[hitWay_i];
    mergedLine[wordSel*`DC_WORD_W +: `DC_WORD_W] = mergedWord;
  end

  assign wrLine  = fill_i ? fillLine_i : mergedLine;
  assign wrEn[0] = (fill_i && !victimWay_i) || (storeHit_i && !hitWay_i);
  assign wrEn[1] = (fill_i && victimWay_i) || (storeHit_i && hitWay_i);

  // write-first: a read of the set being written sees the new line
  always_ff @(posedge clk) begin
    for (int w = 0; w < 2; w++) begin
      if (wrEn[w]) begin
        dataMem[w][heldIndex] <= wrLine;
      end
      if (wrEn[w] && (rdIndex == heldIndex)) begin
        rdLine[w] <= wrLine;
      end else begin
        rdLine[w] <= dataMem[w][rdIndex];
      end
    end
  end

  assign rdWord_o     = hitWord;
  assign victimLine_o = rdLine[victimWay_i];

endmodule

`default_nettype wire

//--- hw/tagStore.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module tagStore (
  input  logic             clk,
  input  logic             rst_n,
  input  dcachePkg::addr_t heldAddr_i,
  input  logic             storeHit_i,
  input  logic             fill_i,
  output logic             hit_o,
  output logic             hitWay_o,
  output logic             victimWay_o,
  output logic             victimDirty_o,
  output dcachePkg::tag_t  victimTag_o
);
  import dcachePkg::*;

  tag_t                     tagMem [2][`DC_SETS];
  logic [1:0][`DC_SETS-1:0] validBits;
  logic [1:0][`DC_SETS-1:0] dirtyBits;
  // per-set replacement pointer, names the next victim way
  logic [`DC_SETS-1:0]      rrBits;

  index_t     idx;
  tag_t       reqTag;
  logic [1:0] wayHit;
  logic       victim;

  assign idx    = heldAddr_i[`DC_OFFSET_W +: `DC_INDEX_W];
  assign reqTag = heldAddr_i[`DC_ADDR_W-1 -: `DC_TAG_W];

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = validBits[w][idx] && (tagMem[w][idx] == reqTag);
    end
  end

  assign hit_o    = |wayHit;
  assign hitWay_o = wayHit[1];

  assign victim        = rrBits[idx];
  assign victimWay_o   = victim;
  assign victimDirty_o = dirtyBits[victim][idx];
  assign victimTag_o   = tagMem[victim][idx];

  // bookkeeping bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
      dirtyBits <= '0;
      rrBits    <= '0;
    end else if (fill_i) begin
      validBits[victim][idx] <= 1'b1;
      dirtyBits[victim][idx] <= 1'b0;
      rrBits[idx]            <= ~rrBits[idx];
    end else if (storeHit_i) begin
      dirtyBits[hitWay_o][idx] <= 1'b1;
    end
  end

  // new tag goes into the way being replaced
  always_ff @(posedge clk) begin
    if (fill_i) begin
      tagMem[victim][idx] <= reqTag;
    end
  end

endmodule

`default_nettype wire

//--- hw/reqStage.sv
`timescale 1ns/1ps
`default_nettype none

module reqStage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 reqValid_i,
  input  dcachePkg::memOp_e    reqOp_i,
  input  dcachePkg::addr_t     reqAddr_i,
  input  dcachePkg::word_t     wrData_i,
  input  dcachePkg::byteMask_t wrMask_i,
  input  logic                 addrOk_i,
  output logic                 accept_o,
  output dcachePkg::addr_t     heldAddr_o,
  output dcachePkg::memOp_e    heldOp_o,
  output dcachePkg::word_t     heldData_o,
  output dcachePkg::byteMask_t heldMask_o
);
  import dcachePkg::*;

  addr_t     addrQ;
  memOp_e    opQ;
  word_t     dataQ;
  byteMask_t maskQ;

  // request taken only while the controller can take a new address
  assign accept_o = reqValid_i && addrOk_i;

  // address and op select the set and the action, so they start known
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addrQ <= '0;
      opQ   <= OP_LOAD;
    end else if (accept_o) begin
      addrQ <= reqAddr_i;
      opQ   <= reqOp_i;
    end
  end

  // store payload, only meaningful for OP_STORE
  always_ff @(posedge clk) begin
    if (accept_o) begin
      dataQ <= wrData_i;
      maskQ <= wrMask_i;
    end
  end

  // held until the next acceptance, i.e. through a whole miss
  assign heldAddr_o = addrQ;
  assign heldOp_o   = opQ;
  assign heldData_o = dataQ;
  assign heldMask_o = maskQ;

endmodule

`default_nettype wire

//--- hw/dcachePkg.sv
`default_nettype none

`include "dcache_defines.svh"

package dcachePkg;

  // controller states
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    COMPARE   = 3'd1,
    WRITEBACK = 3'd2,
    REFILLREQ = 3'd3,
    REFILL    = 3'd4,
    REPLACE   = 3'd5
  } cacheState_e;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } memOp_e;

  typedef logic [`DC_ADDR_W-1:0] addr_t;
  typedef logic [`DC_WORD_W-1:0] word_t;
  typedef logic [`DC_LINE_W-1:0] line_t;
  typedef logic [`DC_TAG_W-1:0] tag_t;
  typedef logic [`DC_INDEX_W-1:0] index_t;
  typedef logic [`DC_MASK_W-1:0] byteMask_t;

endpackage

`default_nettype wire

//--- include/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// address and data widths
`define DC_ADDR_W 32
`define DC_WORD_W 64
`define DC_LINE_W 256

// address split: tag | index | offset
`define DC_OFFSET_W 5
`define DC_INDEX_W 6
`define DC_TAG_W 21

// geometry
`define DC_SETS 64
`define DC_BEATS 4

// one enable bit per byte of a pipeline word
`define DC_MASK_W 8

`endif
